//--- common/wb_bus_pkg.sv
package wb_bus_pkg;

    //////////////////////////////////////////////////
    // bus widths
    //////////////////////////////////////////////////

    // word addressed, one address per 32-bit word
    localparam int WB_AW = 32;

    // data width
    localparam int WB_DW = 32;

    // one select bit per byte lane
    localparam int WB_SW = WB_DW / 8;

    // request word: write enable, byte selects, write data
    localparam int REQ_W = 1 + WB_SW + WB_DW;

    //////////////////////////////////////////////////
    // request word
    //////////////////////////////////////////////////

    // the decoder moves the raw view and never looks inside
    // the consumer reads the field view
    typedef union packed {
        logic [REQ_W-1:0] raw;
        struct packed {
            // msb, write enable
            logic             we;
            // byte lanes to write
            logic [WB_SW-1:0] sel;
            // write payload, lsbs
            logic [WB_DW-1:0] wdata;
        } f;
    } wb_req_t;

endpackage

//--- common/addr_map_pkg.sv
package addr_map_pkg;

    //////////////////////////////////////////////////
    // slave map
    //////////////////////////////////////////////////

    // two scratch RAMs on the bus
    localparam int NUM_SLAVES = 2;

    // base word address per slave, slave 0 in the low word
    localparam logic [NUM_SLAVES*wb_bus_pkg::WB_AW-1:0] SLAVE_BASE = {
        32'h0001_0000,
        32'h0000_0000
    };

    // address bits that take part in the match
    // slave 0 has a nonzero mask, so unmapped space exists
    localparam logic [NUM_SLAVES*wb_bus_pkg::WB_AW-1:0] SLAVE_MASK = {
        32'hFFFF_0000,
        32'hFFFF_0000
    };

    //////////////////////////////////////////////////
    // RAM sizes
    //////////////////////////////////////////////////

    // words in RAM 0, index wraps past this
    localparam int RAM0_DEPTH = 64;

    // words in RAM 1
    localparam int RAM1_DEPTH = 16;

endpackage

//--- source/scratch_ram.sv
`timescale 1ns/10ps

module scratch_ram #(
    parameter int DEPTH = addr_map_pkg::RAM0_DEPTH
) (
    input  logic                         clock,
    input  logic                         i_stb,
    input  logic                         i_we,
    input  logic [wb_bus_pkg::WB_AW-1:0] i_idx,
    input  logic [wb_bus_pkg::WB_SW-1:0] i_sel,
    input  logic [wb_bus_pkg::WB_DW-1:0] i_wdat,
    output logic                         o_ack,
    output logic [wb_bus_pkg::WB_DW-1:0] o_dat
);

    import wb_bus_pkg::*;

    // index bits, at least one
    localparam int IW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WB_DW-1:0] mem [DEPTH];
    logic [IW-1:0]    word_idx;

    // wrap the bus address onto the array
    assign word_idx = IW'(i_idx % DEPTH);

    //////////////////////////////////////////////////
    // access
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        // reply one cycle after the strobe
        o_ack <= i_stb;
        if (i_stb) begin
            // old word, also on writes
            o_dat <= mem[word_idx];
            if (i_we) begin
                // only the enabled byte lanes change
                for (int b = 0; b < WB_SW; b++) begin
                    if (i_sel[b]) begin
                        mem[word_idx][8*b +: 8] <= i_wdat[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- source/wb_request_port.sv
`timescale 1ns/10ps

module wb_request_port (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             i_cyc,
    input  logic                             i_stb,
    input  logic                             i_we,
    input  logic [wb_bus_pkg::WB_AW-1:0]     i_adr,
    input  logic [wb_bus_pkg::WB_DW-1:0]     i_dat,
    input  logic [wb_bus_pkg::WB_SW-1:0]     i_sel,
    input  logic                             i_stall,
    input  logic                             i_done,
    input  logic                             i_done_err,
    input  logic [wb_bus_pkg::WB_DW-1:0]     i_done_dat,
    output logic                             o_ack,
    output logic                             o_err,
    output logic [wb_bus_pkg::WB_DW-1:0]     o_dat,
    output logic                             o_valid,
    output logic [wb_bus_pkg::WB_AW-1:0]     o_addr,
    output wb_bus_pkg::wb_req_t              o_req
);

    // fsm encoding
    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_BUSY = 1'b1;

    logic r_state;
    logic start;

    // new cycle only when idle and the last reply has gone away
    assign start = (r_state == ST_IDLE) && i_cyc && i_stb && !o_ack && !o_err;

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            r_state <= ST_IDLE;
            o_valid <= 1'b0;
            o_ack   <= 1'b0;
            o_err   <= 1'b0;
        end else begin
            // reply pulse, hidden if the master dropped cyc
            o_ack <= i_done && !i_done_err && i_cyc;
            o_err <= i_done && i_done_err && i_cyc;
            case (r_state)
                ST_IDLE: begin
                    if (start) begin
                        r_state <= ST_BUSY;
                        o_valid <= 1'b1;
                    end
                end
                default: begin
                    // beat leaves once the decoder takes it
                    if (o_valid && !i_stall) begin
                        o_valid <= 1'b0;
                    end
                    // reply closes the transfer
                    if (i_done) begin
                        r_state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // payload
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (start) begin
            o_addr        <= i_adr;
            o_req.f.we    <= i_we;
            o_req.f.sel   <= i_sel;
            o_req.f.wdata <= i_dat;
        end
        if (i_done) begin
            o_dat <= i_done_dat;
        end
    end

    // master never sees ack and err at once
    assert property (@(posedge clock) disable iff (reset) !(o_ack && o_err));

    // a reply only comes back for a beat that already left this port
    assert property (@(posedge clock) disable iff (reset)
        i_done |-> (r_state == ST_BUSY) && !o_valid);

endmodule

//--- address_decoder/address_decoder.sv
`timescale 1ns/10ps

module address_decoder #(
    parameter int               NS         = addr_map_pkg::NUM_SLAVES,
    parameter int               AW         = wb_bus_pkg::WB_AW,
    parameter int               DW         = wb_bus_pkg::REQ_W,
    parameter logic [NS*AW-1:0] SLAVE_ADDR = addr_map_pkg::SLAVE_BASE,
    parameter logic [NS*AW-1:0] SLAVE_MASK = addr_map_pkg::SLAVE_MASK
) (
    input  logic          clock,
    input  logic          reset,
    input  logic          i_valid,
    input  logic [AW-1:0] i_addr,
    input  logic [DW-1:0] i_data,
    input  logic          i_stall,
    output logic          o_stall,
    output logic          o_valid,
    output logic [NS:0]   o_decode,
    output logic [AW-1:0] o_addr,
    output logic [DW-1:0] o_data
);

    // a masked slave 0 leaves holes in the map
    // so a separate no-slave line is needed
    localparam logic OPT_NONESEL = (SLAVE_MASK[AW-1:0] != '0);

    logic [NS-1:0] addr_hit;
    logic [NS-1:0] slave_req;
    logic          none_req;
    logic [NS:0]   request;
    logic          load;

    //////////////////////////////////////////////////
    // address match
    //////////////////////////////////////////////////

    // compare only the bits the mask keeps
    always_comb begin
        for (int s = 0; s < NS; s++) begin
            addr_hit[s] = ((i_addr ^ SLAVE_ADDR[s*AW +: AW])
                           & SLAVE_MASK[s*AW +: AW]) == '0;
        end
    end

    generate
        if (OPT_NONESEL) begin : g_nonesel
            always_comb begin
                slave_req = {NS{i_valid}} & addr_hit;
                // nothing matched so this becomes a bus error downstream
                none_req = i_valid && (addr_hit == '0);
            end
        end else begin : g_default_slave
            // slave 0 matches everything and takes what others leave
            always_comb begin
                slave_req = {NS{i_valid}} & addr_hit;
                for (int s = 1; s < NS; s++) begin
                    if (addr_hit[s]) begin
                        slave_req[0] = 1'b0;
                    end
                end
                none_req = 1'b0;
            end
        end
    endgenerate

    // no-slave flag rides in the top bit
    assign request = {none_req, slave_req};

    //////////////////////////////////////////////////
    // one-beat register stage
    //////////////////////////////////////////////////

    // take a new beat when empty or when the held one moves on
    assign load    = !o_valid || !i_stall;
    assign o_stall = o_valid && i_stall;

    always_ff @(posedge clock) begin
        if (reset) begin
            o_valid  <= 1'b0;
            o_decode <= '0;
        end else if (load) begin
            o_valid  <= i_valid;
            o_decode <= request;
        end
    end

    // address and request word carried untouched
    always_ff @(posedge clock) begin
        if (load) begin
            o_addr <= i_addr;
            o_data <= i_data;
        end
    end

    // overlapping or missing map entries would break this
    assert property (@(posedge clock) disable iff (reset)
        o_valid |-> $onehot(o_decode));

    // the producer keeps its beat steady while held off
    assert property (@(posedge clock) disable iff (reset)
        i_valid && o_stall |=> i_valid && $stable(i_addr) && $stable(i_data));

endmodule

//--- source/slave_response_mux.sv
`timescale 1ns/10ps

module slave_response_mux #(
    parameter int NS = addr_map_pkg::NUM_SLAVES
) (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            i_valid,
    input  logic [NS:0]                     i_decode,
    input  logic [wb_bus_pkg::WB_AW-1:0]    i_addr,
    input  wb_bus_pkg::wb_req_t             i_req,
    input  logic [NS-1:0]                   i_ram_ack,
    input  logic [NS*wb_bus_pkg::WB_DW-1:0] i_ram_dat,
    output logic                            o_stall,
    output logic [NS-1:0]                   o_ram_stb,
    output logic                            o_ram_we,
    output logic [wb_bus_pkg::WB_AW-1:0]    o_ram_idx,
    output logic [wb_bus_pkg::WB_SW-1:0]    o_ram_sel,
    output logic [wb_bus_pkg::WB_DW-1:0]    o_ram_wdat,
    output logic                            o_done,
    output logic                            o_done_err,
    output logic [wb_bus_pkg::WB_DW-1:0]    o_done_dat
);

    import wb_bus_pkg::*;

    logic             accept;
    logic [NS-1:0]    r_open;
    logic             r_err;
    logic             reply;
    logic [WB_DW-1:0] reply_dat;

    // one access at a time, hold off while one is open
    assign o_stall = (|r_open) || r_err;
    assign accept  = i_valid && !o_stall;

    //////////////////////////////////////////////////
    // strobe and open-access tracking
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            o_ram_stb <= '0;
            r_open    <= '0;
            r_err     <= 1'b0;
        end else begin
            // single-cycle strobe to the selected RAM only
            o_ram_stb <= accept ? i_decode[NS-1:0] : '0;
            // unmapped beat, error done next cycle
            r_err <= accept && i_decode[NS];
            if (accept) begin
                r_open <= i_decode[NS-1:0];
            end else if (reply) begin
                r_open <= '0;
            end
        end
    end

    // request fields, decoded from the union
    always_ff @(posedge clock) begin
        if (accept) begin
            o_ram_we   <= i_req.f.we;
            o_ram_sel  <= i_req.f.sel;
            o_ram_wdat <= i_req.f.wdata;
            // full address, the RAM wraps it
            o_ram_idx  <= i_addr;
        end
    end

    //////////////////////////////////////////////////
    // reply path
    //////////////////////////////////////////////////

    assign reply = |(i_ram_ack & r_open);

    // read data from whichever slave is open
    always_comb begin
        reply_dat = '0;
        for (int s = 0; s < NS; s++) begin
            if (r_open[s]) begin
                reply_dat = reply_dat | i_ram_dat[s*WB_DW +: WB_DW];
            end
        end
    end

    assign o_done     = r_err || reply;
    assign o_done_err = r_err;
    assign o_done_dat = reply_dat;

    // never two RAMs addressed together
    assert property (@(posedge clock) disable iff (reset) $onehot0(o_ram_stb));

    // a RAM only answers the access this block opened
    assert property (@(posedge clock) disable iff (reset)
        (i_ram_ack & ~r_open) == '0);

endmodule

//--- source/wb_subsystem_top.sv
`timescale 1ns/10ps

module wb_subsystem_top (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         i_cyc,
    input  logic                         i_stb,
    input  logic                         i_we,
    input  logic [wb_bus_pkg::WB_AW-1:0] i_adr,
    input  logic [wb_bus_pkg::WB_DW-1:0] i_dat,
    input  logic [wb_bus_pkg::WB_SW-1:0] i_sel,
    output logic                         o_ack,
    output logic                         o_err,
    output logic [wb_bus_pkg::WB_DW-1:0] o_dat
);

    import wb_bus_pkg::*;
    import addr_map_pkg::*;

    // producer to decoder
    logic                        req_valid;
    logic                        req_stall;
    logic [WB_AW-1:0]            req_addr;
    wb_req_t                     req_word;

    // decoder to consumer
    logic                        dec_valid;
    logic                        dec_stall;
    logic [NUM_SLAVES:0]         dec_decode;
    logic [WB_AW-1:0]            dec_addr;
    wb_req_t                     dec_word;

    // consumer back to producer
    logic                        done;
    logic                        done_err;
    logic [WB_DW-1:0]            done_dat;

    // consumer to RAMs, shared except the strobes
    logic [NUM_SLAVES-1:0]       ram_stb;
    logic                        ram_we;
    logic [WB_AW-1:0]            ram_idx;
    logic [WB_SW-1:0]            ram_sel;
    logic [WB_DW-1:0]            ram_wdat;
    logic [NUM_SLAVES-1:0]       ram_ack;
    logic [NUM_SLAVES*WB_DW-1:0] ram_dat;

    //////////////////////////////////////////////////
    // request path
    //////////////////////////////////////////////////

    wb_request_port u_request_port (
        .clock      (clock),
        .reset      (reset),
        .i_cyc      (i_cyc),
        .i_stb      (i_stb),
        .i_we       (i_we),
        .i_adr      (i_adr),
        .i_dat      (i_dat),
        .i_sel      (i_sel),
        .i_stall    (req_stall),
        .i_done     (done),
        .i_done_err (done_err),
        .i_done_dat (done_dat),
        .o_ack      (o_ack),
        .o_err      (o_err),
        .o_dat      (o_dat),
        .o_valid    (req_valid),
        .o_addr     (req_addr),
        .o_req      (req_word)
    );

    address_decoder #(
        .NS         (NUM_SLAVES),
        .AW         (WB_AW),
        .DW         (REQ_W),
        .SLAVE_ADDR (SLAVE_BASE),
        .SLAVE_MASK (SLAVE_MASK)
    ) u_address_decoder (
        .clock    (clock),
        .reset    (reset),
        .i_valid  (req_valid),
        .i_addr   (req_addr),
        .i_data   (req_word.raw),
        .i_stall  (dec_stall),
        .o_stall  (req_stall),
        .o_valid  (dec_valid),
        .o_decode (dec_decode),
        .o_addr   (dec_addr),
        .o_data   (dec_word.raw)
    );

    slave_response_mux #(
        .NS (NUM_SLAVES)
    ) u_response_mux (
        .clock      (clock),
        .reset      (reset),
        .i_valid    (dec_valid),
        .i_decode   (dec_decode),
        .i_addr     (dec_addr),
        .i_req      (dec_word),
        .i_ram_ack  (ram_ack),
        .i_ram_dat  (ram_dat),
        .o_stall    (dec_stall),
        .o_ram_stb  (ram_stb),
        .o_ram_we   (ram_we),
        .o_ram_idx  (ram_idx),
        .o_ram_sel  (ram_sel),
        .o_ram_wdat (ram_wdat),
        .o_done     (done),
        .o_done_err (done_err),
        .o_done_dat (done_dat)
    );

    //////////////////////////////////////////////////
    // slaves
    //////////////////////////////////////////////////

    // RAM 0 at word 0x0000_0000
    scratch_ram #(
        .DEPTH (RAM0_DEPTH)
    ) u_ram0 (
        .clock  (clock),
        .i_stb  (ram_stb[0]),
        .i_we   (ram_we),
        .i_idx  (ram_idx),
        .i_sel  (ram_sel),
        .i_wdat (ram_wdat),
        .o_ack  (ram_ack[0]),
        .o_dat  (ram_dat[0 +: WB_DW])
    );

    // RAM 1 at word 0x0001_0000
    scratch_ram #(
        .DEPTH (RAM1_DEPTH)
    ) u_ram1 (
        .clock  (clock),
        .i_stb  (ram_stb[1]),
        .i_we   (ram_we),
        .i_idx  (ram_idx),
        .i_sel  (ram_sel),
        .i_wdat (ram_wdat),
        .o_ack  (ram_ack[1]),
        .o_dat  (ram_dat[WB_DW +: WB_DW])
    );

endmodule

//--- bench/tb_wb_subsystem.sv
`timescale 1ns/10ps

module tb_wb_subsystem;

    import wb_bus_pkg::*;
    import addr_map_pkg::*;

    // response kind as {err, ack}
    localparam logic [1:0] RESP_NONE = 2'b00;
    localparam logic [1:0] RESP_ACK  = 2'b01;
    localparam logic [1:0] RESP_ERR  = 2'b10;

    // edges from the sampling edge of stb to the visible reply
    localparam int LAT_RAM      = 4;
    localparam int LAT_UNMAPPED = 3;

    // region index for an address outside both RAMs
    localparam int REGION_NONE = NUM_SLAVES;

    // about 70 accesses of 6 cycles each, budget is generous
    localparam int ACCESS_COUNT      = 80;
    localparam int CYCLES_PER_ACCESS = 20;
    localparam int MAX_CYCLES        = ACCESS_COUNT * CYCLES_PER_ACCESS + 400;

    logic             clock;
    logic             reset;
    logic             i_cyc;
    logic             i_stb;
    logic             i_we;
    logic [WB_AW-1:0] i_adr;
    logic [WB_DW-1:0] i_dat;
    logic [WB_SW-1:0] i_sel;
    logic             o_ack;
    logic             o_err;
    logic [WB_DW-1:0] o_dat;

    // reference copies of both RAMs, X until written like the real ones
    logic [WB_DW-1:0] model0 [RAM0_DEPTH];
    logic [WB_DW-1:0] model1 [RAM1_DEPTH];

    integer seed;
    int     cycle_count;
    int     error_count;
    int     check_count;
    int     tests_run;
    int     tests_failed;
    int     test_errors;
    string  test_name;

    wb_subsystem_top u_dut (
        .clock (clock),
        .reset (reset),
        .i_cyc (i_cyc),
        .i_stb (i_stb),
        .i_we  (i_we),
        .i_adr (i_adr),
        .i_dat (i_dat),
        .i_sel (i_sel),
        .o_ack (o_ack),
        .o_err (o_err),
        .o_dat (o_dat)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // watchdog, ends a hung run
    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("run timed out: still running after %0d cycles", MAX_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // upper half of the word address picks the slave
    function automatic int map_region(input logic [WB_AW-1:0] adr);
        if (adr[31:16] == 16'h0000) begin
            return 0;
        end else if (adr[31:16] == 16'h0001) begin
            return 1;
        end
        return REGION_NONE;
    endfunction

    // byte lanes enabled by sel take the new data
    function automatic logic [WB_DW-1:0] merge_lanes(input logic [WB_DW-1:0] old_word,
                                                     input logic [WB_DW-1:0] new_word,
                                                     input logic [WB_SW-1:0] sel);
        logic [WB_DW-1:0] result;
        result = old_word;
        for (int b = 0; b < WB_SW; b++) begin
            if (sel[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic string kind_name(input logic [1:0] kind);
        case (kind)
            RESP_NONE: return "none";
            RESP_ACK:  return "ack";
            RESP_ERR:  return "err";
            default:   return "ack+err";
        endcase
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic compare_data(input string what, input logic [WB_DW-1:0] expected,
                                input logic [WB_DW-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            test_errors++;
            $display("** Error [%s] %s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic compare_kind(input string what, input logic [1:0] expected,
                                input logic [1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            test_errors++;
            $display("** Error [%s] %s: expected %s, actual %s",
                     test_name, what, kind_name(expected), kind_name(actual));
        end
    endtask

    task automatic compare_latency(input string what, input int expected, input int actual);
        check_count++;
        if (actual != expected) begin
            error_count++;
            test_errors++;
            $display("** Error [%s] %s: expected %0d cycles, actual %0d cycles",
                     test_name, what, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////
    // bus access
    //////////////////////////////////////////////////

    // one classic cycle, called and returning on a falling edge
    // kind_after is the response one cycle after the reply
    task automatic bus_access(input logic we, input logic [WB_AW-1:0] adr,
                              input logic [WB_DW-1:0] dat, input logic [WB_SW-1:0] sel,
                              output logic [1:0] kind, output logic [WB_DW-1:0] rdata,
                              output int latency, output logic [1:0] kind_after);
        int edges;
        edges = 0;
        kind  = RESP_NONE;
        i_cyc = 1'b1;
        i_stb = 1'b1;
        i_we  = we;
        i_adr = adr;
        i_dat = dat;
        i_sel = sel;
        while (kind == RESP_NONE) begin
            @(posedge clock);
            edges++;
            @(negedge clock);
            kind = {o_err, o_ack};
        end
        rdata   = o_dat;
        // first edge is the one that sampled stb
        latency = edges - 1;
        i_cyc   = 1'b0;
        i_stb   = 1'b0;
        i_we    = 1'b0;
        @(negedge clock);
        kind_after = {o_err, o_ack};
    endtask

    // access plus every check the map and model predict for it
    task automatic check_access(input logic we, input logic [WB_AW-1:0] adr,
                                input logic [WB_DW-1:0] dat, input logic [WB_SW-1:0] sel);
        logic [1:0]       kind;
        logic [1:0]       kind_after;
        logic [WB_DW-1:0] rdata;
        logic [WB_DW-1:0] old_word;
        int               latency;
        int               region;
        int               idx;
        region   = map_region(adr);
        idx      = 0;
        old_word = '0;
        if (region == 0) begin
            idx      = adr % RAM0_DEPTH;
            old_word = model0[idx];
        end else if (region == 1) begin
            idx      = adr % RAM1_DEPTH;
            old_word = model1[idx];
        end
        bus_access(we, adr, dat, sel, kind, rdata, latency, kind_after);
        if (region == REGION_NONE) begin
            compare_kind($sformatf("response @%h", adr), RESP_ERR, kind);
            compare_latency($sformatf("latency @%h", adr), LAT_UNMAPPED, latency);
        end else begin
            compare_kind($sformatf("response @%h", adr), RESP_ACK, kind);
            compare_latency($sformatf("latency @%h", adr), LAT_RAM, latency);
            // writes return the word as it was before
            compare_data($sformatf("data @%h", adr), old_word, rdata);
            if (we && region == 0) begin
                model0[idx] = merge_lanes(old_word, dat, sel);
            end else if (we) begin
                model1[idx] = merge_lanes(old_word, dat, sel);
            end
        end
        // reply is a single-cycle pulse
        compare_kind($sformatf("after response @%h", adr), RESP_NONE, kind_after);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic test_reset_state();
        begin_test("reset_state");
        repeat (20) begin
            @(negedge clock);
            compare_kind("idle bus", RESP_NONE, {o_err, o_ack});
        end
        end_test();
    endtask

    task automatic test_full_word();
        begin_test("full_word");
        for (int i = 0; i < 4; i++) begin
            check_access(1'b1, 32'(i * 7), $random(seed), 4'hF);
            check_access(1'b1, 32'h0001_0000 + 32'(i * 5), $random(seed), 4'hF);
        end
        for (int i = 0; i < 4; i++) begin
            check_access(1'b0, 32'(i * 7), '0, 4'hF);
            check_access(1'b0, 32'h0001_0000 + 32'(i * 5), '0, 4'hF);
        end
        end_test();
    endtask

    task automatic test_byte_lanes();
        logic [WB_SW-1:0] lanes [3];
        lanes[0] = 4'b0001;
        lanes[1] = 4'b0110;
        lanes[2] = 4'b1000;
        begin_test("byte_lanes");
        check_access(1'b1, 32'd40, $random(seed), 4'hF);
        check_access(1'b1, 32'h0001_000A, $random(seed), 4'hF);
        for (int i = 0; i < 3; i++) begin
            check_access(1'b1, 32'd40, $random(seed), lanes[i]);
            check_access(1'b0, 32'd40, '0, 4'hF);
            check_access(1'b1, 32'h0001_000A, $random(seed), lanes[i]);
            check_access(1'b0, 32'h0001_000A, '0, 4'hF);
        end
        end_test();
    endtask

    task automatic test_modulo_wrap();
        begin_test("modulo_wrap");
        // word 64+3 lands on word 3 of RAM 0
        check_access(1'b1, 32'(RAM0_DEPTH + 3), $random(seed), 4'hF);
        check_access(1'b0, 32'd3, '0, 4'hF);
        // RAM 1 wraps at 16
        check_access(1'b1, 32'h0001_0000 + 32'(RAM1_DEPTH + 5), $random(seed), 4'hF);
        check_access(1'b0, 32'h0001_0005, '0, 4'hF);
        check_access(1'b0, 32'(2 * RAM0_DEPTH + 3), '0, 4'hF);
        end_test();
    endtask

    task automatic test_unmapped();
        begin_test("unmapped");
        check_access(1'b0, 32'h0002_0000, '0, 4'hF);
        check_access(1'b1, 32'hFFFF_0000, $random(seed), 4'hF);
        // bus still usable after an error
        check_access(1'b1, 32'h0001_0003, $random(seed), 4'hF);
        check_access(1'b0, 32'h0001_0003, '0, 4'hF);
        end_test();
    endtask

    task automatic test_back_to_back();
        logic [31:0]      r;
        logic [WB_AW-1:0] adr;
        begin_test("back_to_back");
        for (int n = 0; n < 30; n++) begin
            r = $random(seed);
            case (r % 3)
                0: adr = 32'(r[12:4]);
                1: adr = 32'h0001_0000 | 32'(r[9:4]);
                default: adr = r[3] ? (32'h0002_0000 | 32'(r[19:4]))
                                    : (32'hFFFF_0000 | 32'(r[19:4]));
            endcase
            // next request goes out one cycle after the reply
            check_access(r[31], adr, $random(seed), r[30:27]);
        end
        end_test();
    endtask

    //////////////////////////////////////////////////
    // sequence
    //////////////////////////////////////////////////

    initial begin
        reset        = 1'b1;
        i_cyc        = 1'b0;
        i_stb        = 1'b0;
        i_we         = 1'b0;
        i_adr        = '0;
        i_dat        = '0;
        i_sel        = '0;
        seed         = 32'h43e5;
        error_count  = 0;
        check_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        test_reset_state();
        test_full_word();
        test_byte_lanes();
        test_modulo_wrap();
        test_unmapped();
        test_back_to_back();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
common/wb_bus_pkg.sv
common/addr_map_pkg.sv
source/scratch_ram.sv
source/wb_request_port.sv
address_decoder/address_decoder.sv
source/slave_response_mux.sv
source/wb_subsystem_top.sv
bench/tb_wb_subsystem.sv
